// ==== Makefile ====
# Verilator build and run of the switch testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, pass only if the log shows a pass"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -f list.f --top-module switch_tb -Mdir obj_dir
	./obj_dir/Vswitch_tb > sim.log 2>&1; cat sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/frame_scoreboard.sv ====
`include "switch_cfg.svh"

module frame_scoreboard import switch_pkg::*; (
	input logic clk,
	input logic arst_n,
	input port_map_t rx_dv,
	input port_map_t rx_er,
	input byte_t rx_data [`SW_PORTS],
	input port_map_t tx_en,
	input byte_t tx_data [`SW_PORTS],
	output logic failed,
	output int pending [`SW_PORTS]     // frame copies still owed by each source
);

	localparam int NP = `SW_PORTS;

	// one expected-frame queue per source and destination pair
	byte_t exp_bytes [NP*NP][$];
	int exp_len [NP*NP][$];

	byte_t rx_buf [NP][$];
	byte_t tx_buf [NP][$];
	logic rx_bad [NP] = '{default: 1'b0};
	int idle [NP] = '{default: 0};
	int owed [NP] = '{default: 0};
	port_map_t rx_dv_d = '0;
	port_map_t tx_en_d = '0;
	port_map_t seen = '0;

	port_map_t tx_done = '0;
	port_map_t tx_match = '0;
	port_map_t gap_short = '0;
	logic err_match = 1'b0;
	logic err_gap = 1'b0;
	logic err_reset = 1'b0;

	assign failed = err_match | err_gap | err_reset;
	assign pending = owed;

	// low nibble names the ports and an empty map floods
	function automatic port_map_t dest_of(input int src, input byte_t first);
		port_map_t m;
		m = first[NP-1:0];
		m[src] = 1'b0;
		if (m == '0) begin
			m = '1;
			m[src] = 1'b0;
		end
		return m;
	endfunction

	task automatic store_frame(input int src);
		port_map_t m;
		m = dest_of(src, rx_buf[src][0]);
		for (int d = 0; d < NP; d++) begin
			if (m[d]) begin
				for (int i = 0; i < rx_buf[src].size(); i++)
					exp_bytes[src*NP+d].push_back(rx_buf[src][i]);
				exp_len[src*NP+d].push_back(rx_buf[src].size());
				owed[src]++;
			end
		end
	endtask

	// frame must equal the head frame of one source for this port
	task automatic check_frame(input int dst, output logic ok);
		int pair;
		ok = 1'b0;
		for (int s = 0; s < NP; s++) begin
			pair = s * NP + dst;
			if (!ok && exp_len[pair].size() > 0
					&& exp_len[pair][0] == tx_buf[dst].size()) begin
				ok = 1'b1;
				for (int i = 0; i < tx_buf[dst].size(); i++)
					if (exp_bytes[pair][i] != tx_buf[dst][i])
						ok = 1'b0;
				if (ok) begin
					for (int i = 0; i < tx_buf[dst].size(); i++)
						void'(exp_bytes[pair].pop_front());
					void'(exp_len[pair].pop_front());
					owed[s]--;
				end
			end
		end
	endtask

	always @(posedge clk) begin
		logic ok;
		tx_done <= '0;
		tx_match <= '0;
		gap_short <= '0;
		for (int p = 0; p < NP; p++) begin
			if (rx_dv[p]) begin
				if (!rx_dv_d[p]) begin
					rx_buf[p].delete();
					rx_bad[p] = 1'b0;
				end
				rx_buf[p].push_back(rx_data[p]);
				rx_bad[p] = rx_bad[p] | rx_er[p];
			end else if (rx_dv_d[p] && !rx_bad[p] && rx_buf[p].size() <= `SW_MAX_FRAME) begin
				store_frame(p);
			end

			if (tx_en[p]) begin
				if (!tx_en_d[p]) begin
					if (seen[p] && idle[p] < `SW_IFG)
						gap_short[p] <= 1'b1;
					tx_buf[p].delete();
				end
				tx_buf[p].push_back(tx_data[p]);
				idle[p] = 0;
				seen[p] = 1'b1;
			end else begin
				idle[p] = idle[p] + 1;
				if (tx_en_d[p]) begin    // end of frame on tx_en falling
					check_frame(p, ok);
					tx_done[p] <= 1'b1;
					tx_match[p] <= ok;
				end
			end
		end
		rx_dv_d = rx_dv;
		tx_en_d = tx_en;
	end

	a_frame_match: assert property (@(posedge clk) disable iff (!arst_n)
		(tx_done & ~tx_match) == '0)
		else begin
			$display("ERROR %0t: transmitted frame matches no expected frame", $time);
			err_match = 1'b1;
		end

	a_gap: assert property (@(posedge clk) disable iff (!arst_n)
		gap_short == '0)
		else begin
			$display("ERROR %0t: inter-frame gap shorter than %0d cycles", $time, `SW_IFG);
			err_gap = 1'b1;
		end

	a_idle_after_reset: assert property (@(posedge clk)
		$rose(arst_n) |-> (tx_en == '0))
		else begin
			$display("ERROR %0t: tx_en high right after reset, value %b", $time, tx_en);
			err_reset = 1'b1;
		end

endmodule

// ==== bench/switch_tb.sv ====
`include "switch_cfg.svh"

module switch_tb import switch_pkg::*; ();

	localparam int NP = `SW_PORTS;
	localparam int LOAD_FRAMES = 30;
	// whole run is near 6000 cycles
	localparam int TIMEOUT_CYCLES = 20000;

	logic clk = 1'b0;
	logic arst_n;
	port_map_t rx_dv;
	port_map_t rx_er;
	byte_t rx_data [NP];
	port_map_t tx_en;
	byte_t tx_data [NP];
	logic sb_failed;
	int pending [NP];
	int cycles = 0;

	switch_top dut0 (
		.clk(clk),
		.arst_n(arst_n),
		.rx_dv(rx_dv),
		.rx_er(rx_er),
		.rx_data(rx_data),
		.tx_en(tx_en),
		.tx_data(tx_data)
	);

	frame_scoreboard sb0 (
		.clk(clk),
		.arst_n(arst_n),
		.rx_dv(rx_dv),
		.rx_er(rx_er),
		.rx_data(rx_data),
		.tx_en(tx_en),
		.tx_data(tx_data),
		.failed(sb_failed),
		.pending(pending)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
		cycles <= cycles + 1;

	function automatic byte_t first_byte(input port_map_t dst);
		byte_t b;
		b = byte_t'($urandom);
		b[NP-1:0] = dst;
		return b;
	endfunction

	function automatic int owed_total();
		int n;
		n = 0;
		for (int s = 0; s < NP; s++)
			n += pending[s];
		return n;
	endfunction

	// err_at below zero gives a clean frame
	task automatic send_frame(input int p, input byte_t first, input int len, input int err_at);
		for (int i = 0; i < len; i++) begin
			@(negedge clk);
			rx_dv[p] = 1'b1;
			rx_er[p] = (i == err_at);
			rx_data[p] = (i == 0) ? first : byte_t'($urandom);
		end
		@(negedge clk);
		rx_dv[p] = 1'b0;
		rx_er[p] = 1'b0;
		rx_data[p] = '0;
		repeat (2) @(negedge clk);
	endtask

	task automatic wait_delivered();
		while (owed_total() != 0)
			@(negedge clk);
	endtask

	task automatic random_traffic(input int p);
		for (int k = 0; k < LOAD_FRAMES; k++) begin
			send_frame(p, byte_t'($urandom), $urandom_range(32, 2), -1);
			while (pending[p] > 3)  // keeps rx queue inside 128 bytes and 4 lengths
				@(negedge clk);
		end
	endtask

	initial begin
		byte_t fb;
		arst_n = 1'b0;
		rx_dv = '0;
		rx_er = '0;
		for (int p = 0; p < NP; p++)
			rx_data[p] = '0;
		void'($urandom(32'ha3a1));
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		for (int s = 0; s < NP; s++)
			for (int d = 0; d < NP; d++)
				if (d != s)
					send_frame(s, first_byte(port_map_t'(1 << d)), $urandom_range(40, 8), -1);
		wait_delivered();

		// zero map and own-bit map both flood
		for (int s = 0; s < NP; s++) begin
			send_frame(s, first_byte('0), $urandom_range(40, 8), -1);
			send_frame(s, first_byte(port_map_t'(1 << s)), $urandom_range(40, 8), -1);
		end
		wait_delivered();

		fb = first_byte(4'b0001);
		send_frame(1, fb, 20, 5);
		send_frame(1, fb, 20, -1);
		wait_delivered();

		fb = first_byte(4'b1000);
		send_frame(2, fb, `SW_MAX_FRAME + 1, -1);
		send_frame(2, fb, `SW_MAX_FRAME, -1);
		wait_delivered();

		// queued back to back on port 1, gap set by the mac
		for (int k = 0; k < 3; k++)
			send_frame(0, first_byte(4'b0010), 10, -1);
		wait_delivered();

		fork
			random_traffic(0);
			random_traffic(1);
			random_traffic(2);
			random_traffic(3);
		join
		wait_delivered();
		repeat (2) @(posedge clk);

		if (sb_failed) begin
			$display("test failed");
			$fatal(1, "scoreboard reported an error");
		end else begin
			$display("test passed");
			$finish;
		end
	end

	initial begin
		wait (sb_failed);
		$display("test failed");
		$fatal(1, "frame check reported an error");
	end

	initial begin
		wait (cycles >= TIMEOUT_CYCLES);
		$display("timeout: frames still not delivered after %0d cycles", cycles);
		$display("test failed");
		$fatal(1, "run stopped by the cycle limit");
	end

endmodule

// ==== hw/ingress_mux.sv ====
`include "switch_cfg.svh"

module ingress_mux import switch_pkg::*; #(
	parameter int SRC_COUNT = `SW_PORTS
) (
	input logic clk,
	input logic arst_n,
	rx_queue_if.mux rxq [SRC_COUNT],
	frame_if.source fb
);

	mux_state_t state;
	logic [SRC_COUNT-1:0] empty_v;
	logic [SRC_COUNT-1:0] ptr_rd_v;
	logic [SRC_COUNT-1:0] data_rd_v;
	frame_len_t len_v [SRC_COUNT];
	byte_t dout_v [SRC_COUNT];
	port_id_t pick;
	port_id_t src_q;        // port being served, also the round-robin origin
	logic found;
	logic start;
	logic rd_en;
	frame_len_t len_q;
	frame_len_t remain;
	frame_len_t byte_cnt;
	port_map_t src_bit;
	port_map_t raw_map;
	port_map_t first_map;
	port_map_t map_q;

	for (genvar i = 0; i < SRC_COUNT; i++) begin : g_src
		assign empty_v[i] = rxq[i].ptr_empty;
		assign len_v[i] = rxq[i].ptr_dout;
		assign dout_v[i] = rxq[i].data_dout;
		assign rxq[i].ptr_rd = ptr_rd_v[i];
		assign rxq[i].data_rd = data_rd_v[i];
	end

	// search from one past the last port served, nearest wins
	always_comb begin
		int idx;
		pick = src_q;
		found = 1'b0;
		for (int k = SRC_COUNT; k >= 1; k--) begin
			idx = (int'(src_q) + k) % SRC_COUNT;
			if (!empty_v[idx]) begin
				pick = port_id_t'(idx);
				found = 1'b1;
			end
		end
	end

	assign start = (state == MUX_IDLE) && found && !(|fb.bp);
	assign rd_en = (state != MUX_IDLE) && (remain != '0);
	assign ptr_rd_v = start ? (SRC_COUNT'(1) << pick) : '0;
	assign data_rd_v = rd_en ? (SRC_COUNT'(1) << src_q) : '0;

	// forwarding rule on the first byte
	assign src_bit = port_map_t'(1) << src_q;
	assign raw_map = port_map_t'(dout_v[src_q]) & ~src_bit;
	assign first_map = (raw_map != '0) ? raw_map : ~src_bit;   // flood

	assign fb.data = dout_v[src_q];
	assign fb.portmap = fb.sof ? first_map : map_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= MUX_IDLE;
			src_q <= port_id_t'(SRC_COUNT - 1);   // so port 0 is tried first
			len_q <= '0;
			remain <= '0;
			map_q <= '0;
			byte_cnt <= '0;
			fb.sof <= 1'b0;
			fb.dv <= 1'b0;
		end else begin
			fb.dv <= rd_en;
			fb.sof <= rd_en && (state == MUX_LOAD);
			if (rd_en)
				remain <= remain - 1'b1;
			case (state)
				MUX_IDLE: begin
					if (start) begin
						src_q <= pick;
						len_q <= len_v[pick];
						remain <= len_v[pick];
						state <= MUX_LOAD;
					end
				end
				MUX_LOAD: state <= MUX_STREAM;
				MUX_STREAM: begin
					if (remain == '0)
						state <= MUX_IDLE;
				end
				default: state <= MUX_IDLE;
			endcase
			if (fb.sof)
				map_q <= first_map;
			if (fb.sof)
				byte_cnt <= frame_len_t'(1);
			else if (fb.dv)
				byte_cnt <= byte_cnt + 1'b1;
		end
	end

	// frame on the bus is as long as the receive queue said
	a_dv_len: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(fb.dv) |-> (byte_cnt == len_q))
		else $error("frame bus length differs from stored length");

endmodule

// ==== hw/rx_port_queue.sv ====
`include "switch_cfg.svh"

module rx_port_queue import switch_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic rx_dv,
	input logic rx_er,
	input byte_t rx_data,
	rx_queue_if.queue q
);

	localparam int DEPTH = `SW_RXQ_DEPTH;
	localparam int AW = $clog2(DEPTH);
	localparam int PD = `SW_PTR_DEPTH;
	localparam int PAW = $clog2(PD);
	localparam int PCW = $clog2(PD + 1);

	byte_t mem [DEPTH];
	frame_len_t len_mem [PD];

	logic [AW:0] wr_ptr;
	logic [AW:0] wr_base;   // start of the frame being captured
	logic [AW:0] rd_ptr;
	logic [PAW-1:0] pwr;
	logic [PAW-1:0] prd;
	logic [PCW-1:0] pcnt;
	logic dv_d;
	frame_len_t len;
	logic bad;              // error flag or no room seen
	logic too_long;
	logic full;
	logic sof;
	logic eof;
	logic drop;
	logic push;

	assign full = (wr_ptr - rd_ptr) == (AW + 1)'(DEPTH);
	assign sof = rx_dv & ~dv_d;
	assign eof = ~rx_dv & dv_d;    // first idle cycle after the frame
	assign drop = bad | too_long | (pcnt == PCW'(PD));
	assign push = eof & ~drop;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dv_d <= 1'b0;
			len <= '0;
			bad <= 1'b0;
			too_long <= 1'b0;
			wr_ptr <= '0;
			wr_base <= '0;
		end else begin
			dv_d <= rx_dv;
			if (sof) begin
				len <= frame_len_t'(1);
				bad <= rx_er | full;
				too_long <= 1'b0;
			end else if (rx_dv) begin
				bad <= bad | rx_er | full;
				if (len == frame_len_t'(`SW_MAX_FRAME))
					too_long <= 1'b1;   // len saturates here
				else
					len <= len + 1'b1;
			end
			if (rx_dv && !full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end else if (eof) begin
				if (drop)
					wr_ptr <= wr_base;  // rewind over the bad frame
				else
					wr_base <= wr_ptr;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_dv && !full)
			mem[wr_ptr[AW-1:0]] <= rx_data;
		if (q.data_rd)
			q.data_dout <= mem[rd_ptr[AW-1:0]];
		if (push)
			len_mem[pwr] <= len;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= '0;
			pwr <= '0;
			prd <= '0;
			pcnt <= '0;
		end else begin
			if (q.data_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (push)
				pwr <= pwr + 1'b1;
			if (q.ptr_rd)
				prd <= prd + 1'b1;
			pcnt <= pcnt + PCW'(push) - PCW'(q.ptr_rd);
		end
	end

	assign q.ptr_empty = (pcnt == '0);
	assign q.ptr_dout = len_mem[prd];

	// the mux must look at ptr_empty before it pops
	a_pop_not_empty: assert property (@(posedge clk) disable iff (!arst_n)
		q.ptr_rd |-> !q.ptr_empty)
		else $error("rx queue length popped while empty");

endmodule

// ==== hw/switch_cfg.svh ====
`ifndef SWITCH_CFG_SVH
`define SWITCH_CFG_SVH

// port count of the switch core
`define SW_PORTS 4

// longest frame in bytes, anything longer is dropped at receive
`define SW_MAX_FRAME 64

// byte storage per queue
`define SW_RXQ_DEPTH 128
`define SW_TXQ_DEPTH 256

// frame length entries per queue
`define SW_PTR_DEPTH 4

// idle cycles on tx_en after each frame
`define SW_IFG 12

`endif

// ==== hw/switch_if.sv ====
// receive queue to ingress mux
interface rx_queue_if import switch_pkg::*; ();
	logic ptr_empty;
	frame_len_t ptr_dout;   // length of head frame
	byte_t data_dout;
	logic ptr_rd;
	logic data_rd;          // byte shows on data_dout one cycle later

	modport queue (output ptr_empty, ptr_dout, data_dout, input ptr_rd, data_rd);
	modport mux (input ptr_empty, ptr_dout, data_dout, output ptr_rd, data_rd);
endinterface

// broadcast frame bus, one frame at a time
interface frame_if import switch_pkg::*; ();
	logic sof;
	logic dv;
	byte_t data;
	port_map_t portmap;     // destinations, held for the whole frame
	port_map_t bp;          // one bit from each transmit queue

	modport source (output sof, dv, data, portmap, input bp);
	modport sink (input sof, dv, data, portmap, output bp);
endinterface

// transmit queue to tx mac
interface egress_if import switch_pkg::*; ();
	logic ptr_empty;
	frame_len_t ptr_dout;
	byte_t data_dout;
	logic ptr_rd;
	logic data_rd;

	modport queue (output ptr_empty, ptr_dout, data_dout, input ptr_rd, data_rd);
	modport mac (input ptr_empty, ptr_dout, data_dout, output ptr_rd, data_rd);
endinterface

// ==== hw/switch_pkg.sv ====
`include "switch_cfg.svh"

package switch_pkg;

	typedef logic [7:0] byte_t;

	// one bit per port, bit n is port n
	typedef logic [`SW_PORTS-1:0] port_map_t;
	typedef logic [$clog2(`SW_PORTS)-1:0] port_id_t;

	// wide enough for SW_MAX_FRAME itself
	typedef logic [$clog2(`SW_MAX_FRAME + 1)-1:0] frame_len_t;

	typedef enum logic [1:0] {
		MUX_IDLE,
		MUX_LOAD,   // length taken, first byte requested
		MUX_STREAM
	} mux_state_t;

	typedef enum logic [1:0] {
		MAC_IDLE,
		MAC_LOAD,
		MAC_SEND,
		MAC_GAP     // inter-frame gap
	} mac_state_t;

endpackage

// ==== hw/switch_top.sv ====
`include "switch_cfg.svh"

module switch_top import switch_pkg::*; (
	input logic clk,
	input logic arst_n,
	input port_map_t rx_dv,
	input port_map_t rx_er,
	input byte_t rx_data [`SW_PORTS],
	output port_map_t tx_en,
	output byte_t tx_data [`SW_PORTS]
);

	rx_queue_if rxq [`SW_PORTS] ();
	egress_if egq [`SW_PORTS] ();
	frame_if fb ();

	for (genvar i = 0; i < `SW_PORTS; i++) begin : g_rx
		rx_port_queue u_rxq (
			.clk(clk),
			.arst_n(arst_n),
			.rx_dv(rx_dv[i]),
			.rx_er(rx_er[i]),
			.rx_data(rx_data[i]),
			.q(rxq[i].queue)
		);
	end

	ingress_mux #(
		.SRC_COUNT(`SW_PORTS)
	) u_mux (
		.clk(clk),
		.arst_n(arst_n),
		.rxq(rxq),
		.fb(fb.source)
	);

	for (genvar i = 0; i < `SW_PORTS; i++) begin : g_tx
		tx_port_queue #(
			.PORT_ID(port_id_t'(i))
		) u_txq (
			.clk(clk),
			.arst_n(arst_n),
			.fb(fb.sink),
			.q(egq[i].queue)
		);

		tx_mac u_mac (
			.clk(clk),
			.arst_n(arst_n),
			.q(egq[i].mac),
			.tx_en(tx_en[i]),
			.tx_data(tx_data[i])
		);
	end

endmodule

// ==== hw/tx_mac.sv ====
`include "switch_cfg.svh"

module tx_mac import switch_pkg::*; (
	input logic clk,
	input logic arst_n,
	egress_if.mac q,
	output logic tx_en,
	output byte_t tx_data
);

	// two idle cycles come from the pop and first read of the next frame
	localparam int GAP_CYCLES = `SW_IFG - 2;
	localparam int GW = $clog2(`SW_IFG);

	mac_state_t state;
	frame_len_t remain;
	logic [GW-1:0] gap_cnt;
	logic rd_en;

	assign q.ptr_rd = (state == MAC_IDLE) && !q.ptr_empty;
	assign rd_en = ((state == MAC_LOAD) || (state == MAC_SEND)) && (remain != '0);
	assign q.data_rd = rd_en;
	assign tx_data = q.data_dout;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= MAC_IDLE;
			remain <= '0;
			gap_cnt <= '0;
			tx_en <= 1'b0;
		end else begin
			tx_en <= rd_en;     // byte arrives one cycle after the read
			if (rd_en)
				remain <= remain - 1'b1;
			case (state)
				MAC_IDLE: begin
					if (!q.ptr_empty) begin
						remain <= q.ptr_dout;
						state <= MAC_LOAD;
					end
				end
				MAC_LOAD: state <= MAC_SEND;
				MAC_SEND: begin
					if (remain == '0) begin
						gap_cnt <= GW'(GAP_CYCLES - 1);
						state <= MAC_GAP;
					end
				end
				MAC_GAP: begin
					if (gap_cnt == '0)
						state <= MAC_IDLE;
					else
						gap_cnt <= gap_cnt - 1'b1;
				end
				default: state <= MAC_IDLE;
			endcase
		end
	end

	a_ifg: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(tx_en) |-> !tx_en [* `SW_IFG])
		else $error("inter-frame gap too short");

endmodule

// ==== hw/tx_port_queue.sv ====
`include "switch_cfg.svh"

module tx_port_queue import switch_pkg::*; #(
	parameter port_id_t PORT_ID = '0
) (
	input logic clk,
	input logic arst_n,
	frame_if.sink fb,
	egress_if.queue q
);

	localparam int DEPTH = `SW_TXQ_DEPTH;
	localparam int AW = $clog2(DEPTH);
	localparam int PD = `SW_PTR_DEPTH;
	localparam int PAW = $clog2(PD);
	localparam int PCW = $clog2(PD + 1);

	byte_t mem [DEPTH];
	frame_len_t len_mem [PD];

	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic [AW:0] used;
	logic [PAW-1:0] pwr;
	logic [PAW-1:0] prd;
	logic [PCW-1:0] pcnt;
	frame_len_t len;
	logic wr;
	logic wr_d;
	logic push;
	logic full;
	logic low_room;

	assign wr = fb.dv & fb.portmap[PORT_ID];
	assign push = wr_d & ~fb.dv;
	assign used = wr_ptr - rd_ptr;
	assign full = (used == (AW + 1)'(DEPTH));
	assign low_room = ((AW + 1)'(DEPTH) - used) < (AW + 1)'(`SW_MAX_FRAME);

	// pending push counts, the pointer lands one cycle late
	assign fb.bp[PORT_ID] = low_room | ((pcnt + PCW'(push)) >= PCW'(PD));

	always_ff @(posedge clk) begin
		if (wr)
			mem[wr_ptr[AW-1:0]] <= fb.data;
		if (q.data_rd)
			q.data_dout <= mem[rd_ptr[AW-1:0]];
		if (push)
			len_mem[pwr] <= len;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_d <= 1'b0;
			len <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			pwr <= '0;
			prd <= '0;
			pcnt <= '0;
		end else begin
			wr_d <= wr;
			if (wr) begin
				wr_ptr <= wr_ptr + 1'b1;
				len <= fb.sof ? frame_len_t'(1) : len + 1'b1;
			end
			if (q.data_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (push)
				pwr <= pwr + 1'b1;
			if (q.ptr_rd)
				prd <= prd + 1'b1;
			pcnt <= pcnt + PCW'(push) - PCW'(q.ptr_rd);
		end
	end

	assign q.ptr_empty = (pcnt == '0);
	assign q.ptr_dout = len_mem[prd];

	// bp sampled at frame start has to cover the whole frame
	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		wr |-> !full)
		else $error("byte written into full tx queue");

endmodule

// ==== list.f ====
+incdir+hw
hw/switch_pkg.sv
hw/switch_if.sv
hw/rx_port_queue.sv
hw/ingress_mux.sv
hw/tx_port_queue.sv
hw/tx_mac.sv
hw/switch_top.sv
bench/frame_scoreboard.sv
bench/switch_tb.sv
